//--- rtl/rf_apb_regs.sv
// APB slave with control, status, word address and indirect array data registers
`timescale 1ns/10ps

module rf_apb_regs
    import rf_pg_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    // APB slave port
    ,input  logic       psel
    ,input  logic       penable
    ,input  logic       pwrite
    ,input  apb_addr_t  paddr
    ,input  apb_data_t  pwdata
    ,output apb_data_t  prdata
    ,output logic       pready
    ,output logic       pslverr

    // Power control towards the sequencer
    ,output logic       power_req
    ,input  pg_state_t  pg_state

    // Array write port
    ,output logic       we
    ,output rf_addr_t   waddr
    ,output rf_data_t   wdata

    // Array read port, data returns one cycle after re
    ,output logic       re
    ,output rf_addr_t   raddr
    ,input  rf_data_t   rdata
);

    // Access phase of a transfer
    logic access;

    // Offset decode
    logic is_ctrl;
    logic is_addr;
    logic is_data;
    logic bad_off;

    // Array traffic is allowed only with the sequencer in PG_ON
    logic pg_on;

    // A MEM_DATA read is waiting for its word, this is the second access cycle
    logic rd_pend_q;

    // Word address used for both array ports
    rf_addr_t mem_addr_q;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    assign access  = psel && penable;
    assign is_ctrl = (paddr == REG_CTRL);
    assign is_addr = (paddr == REG_MEM_ADDR);
    assign is_data = (paddr == REG_MEM_DATA);
    assign bad_off = !is_ctrl && !is_addr && !is_data && (paddr != REG_STATUS);
    assign pg_on   = (pg_state == PG_ON);

    // ------------------------------------------------------------
    // Array strobes
    // ------------------------------------------------------------

    // Writes go out in the first access cycle and finish there
    assign we    = access && pwrite && is_data && pg_on;
    assign waddr = mem_addr_q;
    assign wdata = pwdata[RF_DW-1:0];

    // Read is issued once, in the first access cycle only
    assign re    = access && !pwrite && is_data && pg_on && !rd_pend_q;
    assign raddr = mem_addr_q;

    // ------------------------------------------------------------
    // APB response
    // ------------------------------------------------------------

    // Only the issuing cycle of a read holds the bus, giving one wait state
    assign pready = access && !re;

    // Unpowered data accesses are refused, an accepted read never errors late
    assign pslverr = pready && (bad_off || (is_data && !pg_on && !rd_pend_q));

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_CTRL:     prdata = {31'd0, power_req};
                REG_STATUS:   prdata = {30'd0, pg_state};
                REG_MEM_ADDR: prdata = {{(32-RF_AW){1'b0}}, mem_addr_q};
                // Array word is on rdata only in the wait-state cycle
                REG_MEM_DATA: prdata = rd_pend_q ? {{(32-RF_DW){1'b0}}, rdata} : '0;
                default:      prdata = '0;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power_req  <= 1'b0;
            mem_addr_q <= '0;
            rd_pend_q  <= 1'b0;
        end else begin
            // Set for exactly the cycle after re
            rd_pend_q <= re;

            if (access && pwrite && is_ctrl) begin
                power_req <= pwdata[0];
            end

            // Address steps on every array access and wraps at 64
            if (access && pwrite && is_addr) begin
                mem_addr_q <= pwdata[RF_AW-1:0];
            end else if (we || re) begin
                mem_addr_q <= mem_addr_q + rf_addr_t'(1);
            end
        end
    end

endmodule : rf_apb_regs

//--- rtl/rf_array_64x30.sv
// Behavioral 64x30 two-port array with registered read, power-switch chain and output clamp
`timescale 1ns/10ps

module rf_array_64x30
    import rf_pg_pkg::*;
(
     input  logic      wclk
    ,input  logic      we
    ,input  rf_addr_t  waddr
    ,input  rf_data_t  wdata

    ,input  logic      rclk
    ,input  logic      re
    ,input  rf_addr_t  raddr
    ,output rf_data_t  rdata

    ,input  logic      ip_reset_b

    // Power management
    ,input  logic      pgcb_isol_en
    ,input  logic      pwr_enable_b_in
    ,output logic      pwr_enable_b_out
);

    // Storage, lost whenever the array is powered down
    rf_data_t mem [RF_DEPTH];

    // Power-switch chain, one stage per cycle of switch ramp
    logic [PG_ACK_DELAY-1:0] pwr_chain_q;

    // Read data as captured on rclk, before the isolation clamp
    rf_data_t rdata_q;

    // Array is usable only with power good and isolation released
    logic powered;

    // ------------------------------------------------------------
    // Power switch model
    // ------------------------------------------------------------

    // The chain idles full of ones, meaning the switch is open
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            pwr_chain_q <= '1;
        end else begin
            pwr_chain_q <= {pwr_chain_q[PG_ACK_DELAY-2:0], pwr_enable_b_in};
        end
    end

    // Last stage is the power-good acknowledge back to the sequencer
    assign pwr_enable_b_out = pwr_chain_q[PG_ACK_DELAY-1];

    assign powered = !pwr_enable_b_out && !pgcb_isol_en;

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------

    // Writes while unpowered or isolated are dropped
    always_ff @(posedge wclk) begin
        if (we && powered) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    // One cycle of read latency, the word is held until the next read
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            rdata_q <= '0;
        end else if (re && powered) begin
            rdata_q <= mem[raddr];
        end
    end

    // Isolation forces the output low so no floating value leaves the domain
    assign rdata = pgcb_isol_en ? '0 : rdata_q;

endmodule : rf_array_64x30

//--- rtl/rf_pg_64x30.sv
// Power-gated 64x30 memory wrapper with read-clock reset synchronizer around the array
`timescale 1ns/10ps

module rf_pg_64x30
    import rf_pg_pkg::*;
(
     input  logic      wclk
    ,input  logic      rclk
    ,input  logic      rst_n

    ,input  logic      we
    ,input  rf_addr_t  waddr
    ,input  rf_data_t  wdata

    ,input  logic      re
    ,input  rf_addr_t  raddr
    ,output rf_data_t  rdata

    // Power management
    ,input  logic      pgcb_isol_en
    ,input  logic      pwr_enable_b_in
    ,output logic      pwr_enable_b_out
);

    // Two-flop synchronizer stages for the array reset
    logic [1:0] rst_sync_q;

    // Array reset, asserted at once and released on rclk
    logic ip_reset_b;

    // ------------------------------------------------------------
    // Reset synchronizer
    // ------------------------------------------------------------

    // A one ripples in after rst_n goes high, so release is two rclk edges late
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync_q <= '0;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign ip_reset_b = rst_sync_q[1];

    // ------------------------------------------------------------
    // Array
    // ------------------------------------------------------------

    rf_array_64x30 i_rf (
         .wclk              (wclk)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)
        ,.rclk              (rclk)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata)
        ,.ip_reset_b        (ip_reset_b)
        ,.pgcb_isol_en      (pgcb_isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
    );

endmodule : rf_pg_64x30

//--- rtl/rf_pg_ctrl.sv
// Power-gate sequencer FSM that orders isolation against power enable and acknowledge
`timescale 1ns/10ps

module rf_pg_ctrl
    import rf_pg_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    // Software request, high asks for power on
    ,input  logic       power_req

    // Power-good acknowledge from the switch chain, active low
    ,input  logic       pwr_enable_b_out

    ,output logic       pgcb_isol_en
    ,output logic       pwr_enable_b_in
    ,output pg_state_t  pg_state
);

    // Next values of the registered outputs
    pg_state_t state_nxt;
    logic      isol_nxt;
    logic      pwr_en_b_nxt;

    // ------------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------------

    always_comb begin
        state_nxt    = pg_state;
        isol_nxt     = pgcb_isol_en;
        pwr_en_b_nxt = pwr_enable_b_in;

        case (pg_state)
            // Switch open and outputs clamped, wait for a request
            PG_OFF: begin
                if (power_req) begin
                    pwr_en_b_nxt = 1'b0;
                    state_nxt    = PG_POWER_UP;
                end
            end

            // Isolation stays up until the switch reports power good
            PG_POWER_UP: begin
                if (!pwr_enable_b_out) begin
                    isol_nxt  = 1'b0;
                    state_nxt = PG_ON;
                end
            end

            // Raise isolation first, the switch opens one cycle later
            PG_ON: begin
                if (!power_req) begin
                    isol_nxt  = 1'b1;
                    state_nxt = PG_POWER_DOWN;
                end
            end

            // Open the switch, then wait for the chain to drain to ones
            PG_POWER_DOWN: begin
                pwr_en_b_nxt = 1'b1;
                if (pwr_enable_b_in && pwr_enable_b_out) begin
                    state_nxt = PG_OFF;
                end
            end

            // Unreachable with a 2-bit encoding, falls back to the safe state
            default: begin
                isol_nxt     = 1'b1;
                pwr_en_b_nxt = 1'b1;
                state_nxt    = PG_OFF;
            end
        endcase
    end

    // ------------------------------------------------------------
    // State and output registers
    // ------------------------------------------------------------

    // Reset leaves the array off, isolated and with the switch open
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pg_state        <= PG_OFF;
            pgcb_isol_en    <= 1'b1;
            pwr_enable_b_in <= 1'b1;
        end else begin
            pg_state        <= state_nxt;
            pgcb_isol_en    <= isol_nxt;
            pwr_enable_b_in <= pwr_en_b_nxt;
        end
    end

endmodule : rf_pg_ctrl

//--- rtl/rf_pg_pkg.sv
// Register file sizes, word and bus types, APB register offsets and power-gate states
package rf_pg_pkg;

    // ------------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------------

    // Number of words held in the register file
    localparam int RF_DEPTH = 64;
    // Word address width, enough to index every word
    localparam int RF_AW = 6;
    // Stored word width
    localparam int RF_DW = 30;

    // Stages in the power-switch chain, i.e. cycles until power-good returns
    localparam int PG_ACK_DELAY = 4;

    // Word address inside the array
    typedef logic [RF_AW-1:0] rf_addr_t;
    // One stored word
    typedef logic [RF_DW-1:0] rf_data_t;

    // ------------------------------------------------------------
    // APB register map
    // ------------------------------------------------------------

    // Byte address seen on the APB
    typedef logic [3:0] apb_addr_t;
    // APB read and write data word
    typedef logic [31:0] apb_data_t;

    // Bit 0 holds the power request
    localparam apb_addr_t REG_CTRL = 4'h0;
    // Bits 1:0 show the sequencer state
    localparam apb_addr_t REG_STATUS = 4'h4;
    // Auto-incrementing word address
    localparam apb_addr_t REG_MEM_ADDR = 4'h8;
    // Indirect window onto the array word at MEM_ADDR
    localparam apb_addr_t REG_MEM_DATA = 4'hC;

    // Power-gate sequencer states, only PG_ON allows array traffic
    typedef enum logic [1:0] {
        PG_OFF        = 2'd0,
        PG_POWER_UP   = 2'd1,
        PG_ON         = 2'd2,
        PG_POWER_DOWN = 2'd3
    } pg_state_t;

endpackage : rf_pg_pkg

//--- rtl/rf_pg_top.sv
// Top level joining the APB register block, power-gate sequencer and memory wrapper
`timescale 1ns/10ps

module rf_pg_top
    import rf_pg_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n
    ,input  logic       psel
    ,input  logic       penable
    ,input  logic       pwrite
    ,input  apb_addr_t  paddr
    ,input  apb_data_t  pwdata
    ,output apb_data_t  prdata
    ,output logic       pready
    ,output logic       pslverr
);

    // Sequencer handshake
    logic      power_req;
    pg_state_t pg_state;
    logic      pgcb_isol_en;
    logic      pwr_enable_b_in;
    logic      pwr_enable_b_out;

    // Array ports
    logic      we;
    rf_addr_t  waddr;
    rf_data_t  wdata;
    logic      re;
    rf_addr_t  raddr;
    rf_data_t  rdata;

    rf_apb_regs i_regs (
         .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite)
        ,.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
        ,.power_req(power_req), .pg_state(pg_state), .we(we), .waddr(waddr), .wdata(wdata)
        ,.re(re), .raddr(raddr), .rdata(rdata)
    );

    rf_pg_ctrl i_ctrl (
         .clk(clk), .rst_n(rst_n), .power_req(power_req), .pwr_enable_b_out(pwr_enable_b_out)
        ,.pgcb_isol_en(pgcb_isol_en), .pwr_enable_b_in(pwr_enable_b_in), .pg_state(pg_state)
    );

    // One clock serves both ports of the wrapper here
    rf_pg_64x30 i_mem (
         .wclk(clk), .rclk(clk), .rst_n(rst_n), .we(we), .waddr(waddr), .wdata(wdata)
        ,.re(re), .raddr(raddr), .rdata(rdata), .pgcb_isol_en(pgcb_isol_en)
        ,.pwr_enable_b_in(pwr_enable_b_in), .pwr_enable_b_out(pwr_enable_b_out)
    );

endmodule : rf_pg_top

//--- tb.f
rtl/rf_pg_pkg.sv
rtl/rf_array_64x30.sv
rtl/rf_pg_64x30.sv
rtl/rf_pg_ctrl.sv
rtl/rf_apb_regs.sv
rtl/rf_pg_top.sv
verif/rf_pg_props.sv
verif/tb_rf_pg_top.sv

//--- verif/rf_pg_props.sv
// Bound assertions on power-gate sequencing order and the APB read wait state
`timescale 1ns/10ps

module rf_pg_props
    import rf_pg_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    // Sequencer outputs
    ,input  pg_state_t  pg_state
    ,input  logic       pgcb_isol_en
    ,input  logic       pwr_enable_b_in

    // Register block strobes and response
    ,input  logic       re
    ,input  logic       pready
    ,input  logic       pslverr
);

    // Count of assertion failures that the testbench adds into its verdict
    int fail_count = 0;

    // ------------------------------------------------------------
    // Power sequencing
    // ------------------------------------------------------------

    // Outputs stay clamped in every state except PG_ON
    isol_outside_on: assert property (@(posedge clk) disable iff (!rst_n)
        (pg_state != PG_ON) |-> pgcb_isol_en)
    else begin
        $error("isolation released while the sequencer is not in PG_ON");
        fail_count++;
    end

    // The switch only moves inside the two transition states
    pwr_en_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(pwr_enable_b_in) |-> (pg_state inside {PG_POWER_UP, PG_POWER_DOWN}))
    else begin
        $error("power enable changed while in PG_ON or PG_OFF");
        fail_count++;
    end

    // ------------------------------------------------------------
    // APB timing
    // ------------------------------------------------------------

    // A read issue cycle holds the bus and the next cycle completes without error
    read_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
        re |-> !pready ##1 (pready && !pslverr))
    else begin
        $error("MEM_DATA read did not complete after exactly one wait state");
        fail_count++;
    end

endmodule : rf_pg_props

// The top level carries every sequencer and register block signal watched above
bind rf_pg_top rf_pg_props i_rf_pg_props (
     .clk              (clk)
    ,.rst_n            (rst_n)
    ,.pg_state         (pg_state)
    ,.pgcb_isol_en     (pgcb_isol_en)
    ,.pwr_enable_b_in  (pwr_enable_b_in)
    ,.re               (re)
    ,.pready           (pready)
    ,.pslverr          (pslverr)
);

//--- verif/tb_rf_pg_top.sv
// Testbench for the power-gated register file with APB tasks, reference model and watchdog
`timescale 1ns/10ps

module tb_rf_pg_top
    import rf_pg_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int HALF_PERIOD    = CLK_PERIOD / 2;
    localparam int SEED           = 55987;
    localparam int MAX_WAITS      = 4;
    localparam int MAX_POLLS      = 12;
    localparam int NUM_RANDOM_OPS = 100;

    // Cycle budget per test, an APB access takes about four cycles
    localparam int TEST_BUDGET [6] = '{40, 80, 600, 1000, 100, 40};

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // Reference copy of the array contents
    rf_data_t model [RF_DEPTH];

    string cur_test;
    int    test_errs;
    int    tests_passed;
    int    tests_failed;

    rf_pg_top i_rf_pg_top (
         .clk      (clk)
        ,.rst_n    (rst_n)
        ,.psel     (psel)
        ,.penable  (penable)
        ,.pwrite   (pwrite)
        ,.paddr    (paddr)
        ,.pwdata   (pwdata)
        ,.prdata   (prdata)
        ,.pready   (pready)
        ,.pslverr  (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------

    initial begin
        int budget;
        budget = 0;
        foreach (TEST_BUDGET[i]) begin
            budget += TEST_BUDGET[i];
        end
        #(2 * budget * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a test stopped making progress", 2 * budget);
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Bookkeeping and checks
    // ------------------------------------------------------------

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("%-16s : PASS", cur_test);
        end else begin
            tests_failed++;
            $display("%-16s : FAIL with %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic check_equal(input string what, input apb_data_t expected,
                               input apb_data_t actual);
        assert (actual === expected) else begin
            $display("** Error: %s: %s expected 0x%08h actual 0x%08h",
                     cur_test, what, expected, actual);
            test_errs++;
        end
    endtask

    // ------------------------------------------------------------
    // APB master
    // ------------------------------------------------------------

    // Outputs are sampled 1 ns before the rising edge, where they have settled
    task automatic transfer(input logic is_write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err, output int waits);
        logic ready;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        #(HALF_PERIOD - 1);
        while (!pready && waits < MAX_WAITS) begin
            @(negedge clk);
            waits++;
            #(HALF_PERIOD - 1);
        end
        ready = pready;
        rdata = prdata;
        err   = pslverr;
        assert (ready) else begin
            $display("%s: no pready on offset 0x%0h after %0d wait states",
                     cur_test, addr, waits);
            test_errs++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data,
                             output logic err, output int waits);
        apb_data_t unused;
        transfer(1'b1, addr, data, unused, err, waits);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data,
                            output logic err, output int waits);
        transfer(1'b0, addr, '0, data, err, waits);
    endtask

    // Polls STATUS until target, only target or the transit state may be seen
    task automatic wait_for_state(input pg_state_t target, input pg_state_t transit);
        apb_data_t data;
        logic      err;
        int        waits;
        int        polls;
        polls = 0;
        do begin
            read_reg(REG_STATUS, data, err, waits);
            polls++;
            assert (data[1:0] == target || data[1:0] == transit) else begin
                $display("** Error: %s: STATUS expected %s or %s actual 0x%08h",
                         cur_test, target.name(), transit.name(), data);
                test_errs++;
            end
        end while (data[1:0] != target && polls < MAX_POLLS);
        check_equal("final STATUS", apb_data_t'(target), data);
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------

    task automatic reset_values();
        apb_data_t data;
        logic      err;
        int        waits;
        begin_test("reset_values");
        read_reg(REG_STATUS, data, err, waits);
        check_equal("STATUS", apb_data_t'(PG_OFF), data);
        read_reg(REG_CTRL, data, err, waits);
        check_equal("CTRL", 0, data);
        read_reg(REG_MEM_ADDR, data, err, waits);
        check_equal("MEM_ADDR", 0, data);
        // Array is off, so the data window refuses at once
        read_reg(REG_MEM_DATA, data, err, waits);
        check_equal("MEM_DATA pslverr", 1, err);
        check_equal("MEM_DATA wait states", 0, waits);
        end_test();
    endtask

    task automatic power_up();
        apb_data_t data;
        logic      err;
        int        waits;
        begin_test("power_up");
        write_reg(REG_CTRL, 1, err, waits);
        check_equal("CTRL pslverr", 0, err);
        wait_for_state(PG_ON, PG_POWER_UP);
        read_reg(REG_CTRL, data, err, waits);
        check_equal("CTRL", 1, data);
        end_test();
    endtask

    task automatic stream_words();
        rf_addr_t  start;
        rf_addr_t  a;
        apb_data_t data;
        logic      err;
        int        waits;
        begin_test("stream_words");
        start = rf_addr_t'($urandom);
        write_reg(REG_MEM_ADDR, apb_data_t'(start), err, waits);
        // Full 32-bit words go out so the unused upper bits are exercised too
        for (int i = 0; i < RF_DEPTH; i++) begin
            data     = $urandom;
            a        = start + rf_addr_t'(i);
            model[a] = data[RF_DW-1:0];
            write_reg(REG_MEM_DATA, data, err, waits);
            check_equal("write pslverr", 0, err);
        end
        write_reg(REG_MEM_ADDR, apb_data_t'(start), err, waits);
        for (int i = 0; i < RF_DEPTH; i++) begin
            a = start + rf_addr_t'(i);
            read_reg(REG_MEM_DATA, data, err, waits);
            check_equal($sformatf("word %0d", a), apb_data_t'(model[a]), data);
            check_equal("read pslverr", 0, err);
            check_equal("read wait states", 1, waits);
        end
        // 64 steps wrap the address back to where it began
        read_reg(REG_MEM_ADDR, data, err, waits);
        check_equal("MEM_ADDR after wrap", apb_data_t'(start), data);
        end_test();
    endtask

    task automatic random_access();
        rf_addr_t  a;
        apb_data_t data;
        logic      err;
        int        waits;
        begin_test("random_access");
        for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
            a = rf_addr_t'($urandom);
            write_reg(REG_MEM_ADDR, apb_data_t'(a), err, waits);
            if ($urandom_range(1, 0) == 1) begin
                data     = $urandom;
                model[a] = data[RF_DW-1:0];
                write_reg(REG_MEM_DATA, data, err, waits);
                check_equal("write pslverr", 0, err);
            end else begin
                read_reg(REG_MEM_DATA, data, err, waits);
                check_equal($sformatf("word %0d", a), apb_data_t'(model[a]), data);
                check_equal("read pslverr", 0, err);
                check_equal("read wait states", 1, waits);
            end
        end
        end_test();
    endtask

    task automatic power_down();
        apb_data_t addr_before;
        apb_data_t data;
        logic      err;
        int        waits;
        begin_test("power_down");
        read_reg(REG_MEM_ADDR, addr_before, err, waits);
        write_reg(REG_CTRL, 0, err, waits);
        wait_for_state(PG_OFF, PG_POWER_DOWN);
        write_reg(REG_MEM_DATA, $urandom, err, waits);
        check_equal("write pslverr", 1, err);
        check_equal("write wait states", 0, waits);
        read_reg(REG_MEM_DATA, data, err, waits);
        check_equal("read pslverr", 1, err);
        check_equal("read prdata", 0, data);
        check_equal("read wait states", 0, waits);
        // Refused accesses leave the word address alone
        read_reg(REG_MEM_ADDR, data, err, waits);
        check_equal("MEM_ADDR", addr_before, data);
        end_test();
    endtask

    task automatic unknown_offset();
        apb_addr_t off;
        apb_data_t data;
        logic      err;
        int        waits;
        begin_test("unknown_offset");
        do begin
            off = apb_addr_t'($urandom);
        end while (off inside {REG_CTRL, REG_STATUS, REG_MEM_ADDR, REG_MEM_DATA});
        read_reg(off, data, err, waits);
        check_equal("read pslverr", 1, err);
        check_equal("read prdata", 0, data);
        write_reg(off, $urandom, err, waits);
        check_equal("write pslverr", 1, err);
        end_test();
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        power_up();
        stream_words();
        random_access();
        power_down();
        unknown_offset();

        $display("Summary: %0d tests passed, %0d tests with errors, %0d property failures",
                 tests_passed, tests_failed, i_rf_pg_top.i_rf_pg_props.fail_count);
        if (tests_failed == 0 && i_rf_pg_top.i_rf_pg_props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_rf_pg_top
